// ==== logic/hdmi_tx_consts.svh ====
`ifndef HDMI_TX_CONSTS_SVH
`define HDMI_TX_CONSTS_SVH

// one pixel, three channels of eight bits
`define HDMI_TX_PIXEL_W 24
`define HDMI_TX_CHAN_W 8

// line buffer word holds two pixels
`define HDMI_TX_WORD_W 48
`define HDMI_TX_ADDR_W 9
`define HDMI_TX_DEPTH 512

// timing counters and settings
`define HDMI_TX_CNT_W 16

// pixel value sent when the source is off
`define HDMI_TX_BLANK {`HDMI_TX_PIXEL_W{1'b0}}

`endif

// ==== logic/hdmi_tx_pkg.sv ====
`include "hdmi_tx_consts.svh"

package hdmi_tx_pkg;

  typedef struct packed {
    logic [`HDMI_TX_CHAN_W-1:0] red;
    logic [`HDMI_TX_CHAN_W-1:0] green;
    logic [`HDMI_TX_CHAN_W-1:0] blue;
  } pixel_t;

  // raw view on the dma side, pixel pair on the read side
  typedef union packed {
    logic [`HDMI_TX_WORD_W-1:0] raw;
    struct packed {
      pixel_t hi;
      pixel_t lo;
    } pair;
  } buf_word_t;

  typedef enum logic [1:0] {
    SRC_OFF     = 2'b00,
    SRC_DMA     = 2'b01,
    SRC_PATTERN = 2'b10,
    SRC_CONST   = 2'b11
  } src_sel_t;

endpackage

// ==== logic/video_sync_if.sv ====
interface video_sync_if;

  logic hs;
  logic vs;
  logic hs_de;
  logic vs_de;
  // combined data enable, built by whoever drives the bundle
  logic de;

  modport source (
    output hs,
    output vs,
    output hs_de,
    output vs_de,
    output de
  );

  modport sink (
    input hs,
    input vs,
    input hs_de,
    input vs_de,
    input de
  );

endinterface

// ==== logic/hdmi_tx_timing.sv ====
`include "hdmi_tx_consts.svh"

module hdmi_tx_timing import hdmi_tx_pkg::*; (
  input  logic                      hdmi_clk,
  input  logic                      hdmi_rst,
  input  src_sel_t                  srcsel,
  input  logic [`HDMI_TX_CNT_W-1:0] hl_width,
  input  logic [`HDMI_TX_CNT_W-1:0] hs_width,
  input  logic [`HDMI_TX_CNT_W-1:0] he_min,
  input  logic [`HDMI_TX_CNT_W-1:0] he_max,
  input  logic [`HDMI_TX_CNT_W-1:0] vf_width,
  input  logic [`HDMI_TX_CNT_W-1:0] vs_width,
  input  logic [`HDMI_TX_CNT_W-1:0] ve_min,
  input  logic [`HDMI_TX_CNT_W-1:0] ve_max,
  video_sync_if.source              sync,
  output logic                      fs_toggle,
  output logic                      status
);

  logic                      enable;
  logic                      fs;
  logic [`HDMI_TX_CNT_W-1:0] h_count;
  logic [`HDMI_TX_CNT_W-1:0] v_count;
  logic [`HDMI_TX_CNT_W-1:0] h_last;
  logic [`HDMI_TX_CNT_W-1:0] v_last;

  assign h_last = hl_width - 1'b1;
  assign v_last = vf_width - 1'b1;

  // status comes up one clock after reset
  always_ff @(posedge hdmi_clk or posedge hdmi_rst) begin
    if (hdmi_rst) begin
      status <= 1'b0;
      enable <= 1'b0;
    end else begin
      status <= 1'b1;
      enable <= (srcsel != SRC_OFF);
    end
  end

  // line and frame counters
  always_ff @(posedge hdmi_clk or posedge hdmi_rst) begin
    if (hdmi_rst) begin
      h_count <= '0;
      v_count <= '0;
    end else if (h_count >= h_last) begin
      h_count <= '0;
      if (v_count >= v_last) begin
        v_count <= '0;
      end else begin
        v_count <= v_count + 1'b1;
      end
    end else begin
      h_count <= h_count + 1'b1;
    end
  end

  // sync and enable windows, one clock behind the counters
  always_ff @(posedge hdmi_clk or posedge hdmi_rst) begin
    if (hdmi_rst) begin
      sync.hs    <= 1'b0;
      sync.vs    <= 1'b0;
      sync.hs_de <= 1'b0;
      sync.vs_de <= 1'b0;
    end else begin
      sync.hs    <= enable && (h_count < hs_width);
      sync.vs    <= enable && (v_count < vs_width);
      sync.hs_de <= enable && (h_count >= he_min) && (h_count < he_max);
      sync.vs_de <= enable && (v_count >= ve_min) && (v_count < ve_max);
    end
  end

  assign sync.de = sync.hs_de & sync.vs_de;

  // frame start, signalled to the dma side as a toggle
  always_ff @(posedge hdmi_clk or posedge hdmi_rst) begin
    if (hdmi_rst) begin
      fs        <= 1'b0;
      fs_toggle <= 1'b0;
    end else begin
      fs <= enable && (h_count == `HDMI_TX_CNT_W'd1) && (v_count == vs_width);
      if (fs) begin
        fs_toggle <= ~fs_toggle;
      end
    end
  end

endmodule

// ==== logic/hdmi_tx_line_buffer.sv ====
`include "hdmi_tx_consts.svh"

module hdmi_tx_line_buffer import hdmi_tx_pkg::*; (
  input  logic                       vdma_clk,
  input  logic                       wr,
  input  logic [`HDMI_TX_ADDR_W-1:0] waddr,
  input  buf_word_t                  wdata,
  input  logic                       hdmi_clk,
  input  logic [`HDMI_TX_ADDR_W-1:0] raddr,
  output buf_word_t                  rdata
);

  buf_word_t mem [`HDMI_TX_DEPTH];

  // write port, dma clock
  always_ff @(posedge vdma_clk) begin
    if (wr) begin
      mem[waddr] <= wdata;
    end
  end

  // registered read port, pixel clock
  always_ff @(posedge hdmi_clk) begin
    rdata <= mem[raddr];
  end

endmodule

// ==== logic/hdmi_tx_line_reader.sv ====
`include "hdmi_tx_consts.svh"

module hdmi_tx_line_reader import hdmi_tx_pkg::*; (
  input  logic                       hdmi_clk,
  input  logic                       hdmi_rst,
  input  logic                       fs_ret_toggle,
  input  logic [`HDMI_TX_ADDR_W-1:0] fs_waddr,
  video_sync_if.sink                 sync_in,
  input  buf_word_t                  rdata,
  output logic [`HDMI_TX_ADDR_W-1:0] buf_raddr,
  output logic [`HDMI_TX_ADDR_W-1:0] raddr_gray,
  video_sync_if.source               sync_out,
  output pixel_t                     pixel,
  output logic                       fs_ret
);

  logic                       ret_m1;
  logic                       ret_m2;
  logic                       ret_m3;
  logic                       fs_ret_s;
  logic [`HDMI_TX_ADDR_W-1:0] fs_waddr_q;
  logic [`HDMI_TX_ADDR_W:0]   raddr;
  logic                       hs_d;
  logic                       vs_d;
  logic                       hs_de_d;
  logic                       vs_de_d;
  logic                       sel_d;
  logic                       sel_2d;
  buf_word_t                  word_q;

  function automatic logic [`HDMI_TX_ADDR_W-1:0] bin_to_gray(
    input logic [`HDMI_TX_ADDR_W-1:0] b
  );
    return b ^ (b >> 1);
  endfunction

  // **********************************************************************
  // return toggle from the dma side
  // **********************************************************************

  always_ff @(posedge hdmi_clk or posedge hdmi_rst) begin
    if (hdmi_rst) begin
      ret_m1 <= 1'b0;
      ret_m2 <= 1'b0;
      ret_m3 <= 1'b0;
      fs_ret <= 1'b0;
    end else begin
      ret_m1 <= fs_ret_toggle;
      ret_m2 <= ret_m1;
      ret_m3 <= ret_m2;
      fs_ret <= fs_ret_s;
    end
  end

  assign fs_ret_s = ret_m2 ^ ret_m3;

  // frame address is stable once the toggle arrives
  always_ff @(posedge hdmi_clk) begin
    if (fs_ret_s) begin
      fs_waddr_q <= fs_waddr;
    end
  end

  // pixel address, two pixels per word, lower one first
  always_ff @(posedge hdmi_clk or posedge hdmi_rst) begin
    if (hdmi_rst) begin
      raddr      <= '0;
      raddr_gray <= '0;
    end else begin
      if (fs_ret) begin
        raddr <= {fs_waddr_q, 1'b0};
      end else if (sync_in.de) begin
        raddr <= raddr + 1'b1;
      end
      raddr_gray <= bin_to_gray(raddr[`HDMI_TX_ADDR_W:1]);
    end
  end

  assign buf_raddr = raddr[`HDMI_TX_ADDR_W:1];

  // two stages, matching the registered buffer read plus the word register
  always_ff @(posedge hdmi_clk or posedge hdmi_rst) begin
    if (hdmi_rst) begin
      hs_d           <= 1'b0;
      vs_d           <= 1'b0;
      hs_de_d        <= 1'b0;
      vs_de_d        <= 1'b0;
      sync_out.hs    <= 1'b0;
      sync_out.vs    <= 1'b0;
      sync_out.hs_de <= 1'b0;
      sync_out.vs_de <= 1'b0;
    end else begin
      hs_d           <= sync_in.hs;
      vs_d           <= sync_in.vs;
      hs_de_d        <= sync_in.hs_de;
      vs_de_d        <= sync_in.vs_de;
      sync_out.hs    <= hs_d;
      sync_out.vs    <= vs_d;
      sync_out.hs_de <= hs_de_d;
      sync_out.vs_de <= vs_de_d;
    end
  end

  assign sync_out.de = sync_out.hs_de & sync_out.vs_de;

  always_ff @(posedge hdmi_clk) begin
    sel_d  <= raddr[0];
    sel_2d <= sel_d;
    word_q <= rdata;
  end

  assign pixel = sel_2d ? word_q.pair.hi : word_q.pair.lo;

endmodule

// ==== logic/hdmi_tx_test_pattern.sv ====
`include "hdmi_tx_consts.svh"

module hdmi_tx_test_pattern import hdmi_tx_pkg::*; (
  input  logic       hdmi_clk,
  input  logic       hdmi_rst,
  input  logic       fs_ret,
  video_sync_if.sink sync,
  input  pixel_t     pixel,
  output pixel_t     pattern,
  output logic       oos
);

  logic [`HDMI_TX_PIXEL_W-1:0] count;

  // counter restarts at each frame return
  always_ff @(posedge hdmi_clk or posedge hdmi_rst) begin
    if (hdmi_rst) begin
      count <= '0;
    end else if (fs_ret) begin
      count <= '0;
    end else if (sync.de) begin
      count <= count + 1'b1;
    end
  end

  assign pattern = pixel_t'(count);

  // dma data is expected to follow the same count
  always_ff @(posedge hdmi_clk or posedge hdmi_rst) begin
    if (hdmi_rst) begin
      oos <= 1'b0;
    end else begin
      oos <= sync.de && (pixel != pattern);
    end
  end

endmodule

// ==== logic/hdmi_tx_pixel_out.sv ====
`include "hdmi_tx_consts.svh"

module hdmi_tx_pixel_out import hdmi_tx_pkg::*; (
  input  logic       hdmi_clk,
  input  logic       hdmi_rst,
  input  src_sel_t   srcsel,
  video_sync_if.sink sync,
  input  pixel_t     dma_pixel,
  input  pixel_t     pattern,
  input  pixel_t     const_rgb,
  input  pixel_t     clip_max,
  input  pixel_t     clip_min,
  output logic       hsync,
  output logic       vsync,
  output logic       data_e,
  output pixel_t     data
);

  logic   hs_d;
  logic   vs_d;
  logic   de_d;
  logic   hs_2d;
  logic   vs_2d;
  logic   de_2d;
  pixel_t sel_data;
  pixel_t clip_data;

  function automatic logic [`HDMI_TX_CHAN_W-1:0] clip_chan(
    input logic [`HDMI_TX_CHAN_W-1:0] val,
    input logic [`HDMI_TX_CHAN_W-1:0] lo,
    input logic [`HDMI_TX_CHAN_W-1:0] hi
  );
    logic [`HDMI_TX_CHAN_W-1:0] res;
    if (val > hi) begin
      res = hi;
    end else if (val < lo) begin
      res = lo;
    end else begin
      res = val;
    end
    return res;
  endfunction

  // sync rides along select, clip and output stages
  always_ff @(posedge hdmi_clk or posedge hdmi_rst) begin
    if (hdmi_rst) begin
      {hs_d, vs_d, de_d}         <= 3'b000;
      {hs_2d, vs_2d, de_2d}      <= 3'b000;
      {hsync, vsync, data_e}     <= 3'b000;
    end else begin
      {hs_d, vs_d, de_d}         <= {sync.hs, sync.vs, sync.de};
      {hs_2d, vs_2d, de_2d}      <= {hs_d, vs_d, de_d};
      {hsync, vsync, data_e}     <= {hs_2d, vs_2d, de_2d};
    end
  end

  always_ff @(posedge hdmi_clk) begin
    // source select
    case (srcsel)
      SRC_DMA:     sel_data <= dma_pixel;
      SRC_PATTERN: sel_data <= pattern;
      SRC_CONST:   sel_data <= const_rgb;
      default:     sel_data <= `HDMI_TX_BLANK;
    endcase
    // per channel clamp
    clip_data.red   <= clip_chan(sel_data.red, clip_min.red, clip_max.red);
    clip_data.green <= clip_chan(sel_data.green, clip_min.green, clip_max.green);
    clip_data.blue  <= clip_chan(sel_data.blue, clip_min.blue, clip_max.blue);
    data            <= clip_data;
  end

endmodule

// ==== logic/hdmi_tx_top.sv ====
`include "hdmi_tx_consts.svh"

module hdmi_tx_top import hdmi_tx_pkg::*; (
  input  logic                        hdmi_clk,
  input  logic                        hdmi_rst,

  // dma side
  input  logic                        vdma_clk,
  input  logic                        vdma_wr,
  input  logic [`HDMI_TX_ADDR_W-1:0]  vdma_waddr,
  input  logic [`HDMI_TX_WORD_W-1:0]  vdma_wdata,
  input  logic                        vdma_fs_ret_toggle,
  input  logic [`HDMI_TX_ADDR_W-1:0]  vdma_fs_waddr,

  // static settings
  input  logic [1:0]                  hdmi_srcsel,
  input  logic [`HDMI_TX_PIXEL_W-1:0] hdmi_const_rgb,
  input  logic [`HDMI_TX_PIXEL_W-1:0] hdmi_clip_max,
  input  logic [`HDMI_TX_PIXEL_W-1:0] hdmi_clip_min,
  input  logic [`HDMI_TX_CNT_W-1:0]   hdmi_hl_width,
  input  logic [`HDMI_TX_CNT_W-1:0]   hdmi_hs_width,
  input  logic [`HDMI_TX_CNT_W-1:0]   hdmi_he_min,
  input  logic [`HDMI_TX_CNT_W-1:0]   hdmi_he_max,
  input  logic [`HDMI_TX_CNT_W-1:0]   hdmi_vf_width,
  input  logic [`HDMI_TX_CNT_W-1:0]   hdmi_vs_width,
  input  logic [`HDMI_TX_CNT_W-1:0]   hdmi_ve_min,
  input  logic [`HDMI_TX_CNT_W-1:0]   hdmi_ve_max,

  // 24-bit video out and status
  output logic                        hdmi_24_hsync,
  output logic                        hdmi_24_vsync,
  output logic                        hdmi_24_data_e,
  output logic [`HDMI_TX_PIXEL_W-1:0] hdmi_24_data,
  output logic                        hdmi_fs_toggle,
  output logic [`HDMI_TX_ADDR_W-1:0]  hdmi_raddr_g,
  output logic                        hdmi_tpm_oos,
  output logic                        hdmi_status
);

  src_sel_t                   srcsel;
  buf_word_t                  wr_word;
  buf_word_t                  rd_word;
  logic [`HDMI_TX_ADDR_W-1:0] buf_raddr;
  logic                       fs_ret;
  pixel_t                     dma_pixel;
  pixel_t                     pattern;

  video_sync_if tim_sync ();
  video_sync_if rd_sync ();

  assign srcsel = src_sel_t'(hdmi_srcsel);
  assign wr_word.raw = vdma_wdata;

  // **********************************************************************
  // timing and line buffer
  // **********************************************************************

  hdmi_tx_timing timing_inst (
    .hdmi_clk  (hdmi_clk),
    .hdmi_rst  (hdmi_rst),
    .srcsel    (srcsel),
    .hl_width  (hdmi_hl_width),
    .hs_width  (hdmi_hs_width),
    .he_min    (hdmi_he_min),
    .he_max    (hdmi_he_max),
    .vf_width  (hdmi_vf_width),
    .vs_width  (hdmi_vs_width),
    .ve_min    (hdmi_ve_min),
    .ve_max    (hdmi_ve_max),
    .sync      (tim_sync),
    .fs_toggle (hdmi_fs_toggle),
    .status    (hdmi_status)
  );

  hdmi_tx_line_buffer line_buffer_inst (
    .vdma_clk (vdma_clk),
    .wr       (vdma_wr),
    .waddr    (vdma_waddr),
    .wdata    (wr_word),
    .hdmi_clk (hdmi_clk),
    .raddr    (buf_raddr),
    .rdata    (rd_word)
  );

  // **********************************************************************
  // read side pixel path
  // **********************************************************************

  hdmi_tx_line_reader line_reader_inst (
    .hdmi_clk      (hdmi_clk),
    .hdmi_rst      (hdmi_rst),
    .fs_ret_toggle (vdma_fs_ret_toggle),
    .fs_waddr      (vdma_fs_waddr),
    .sync_in       (tim_sync),
    .rdata         (rd_word),
    .buf_raddr     (buf_raddr),
    .raddr_gray    (hdmi_raddr_g),
    .sync_out      (rd_sync),
    .pixel         (dma_pixel),
    .fs_ret        (fs_ret)
  );

  hdmi_tx_test_pattern test_pattern_inst (
    .hdmi_clk (hdmi_clk),
    .hdmi_rst (hdmi_rst),
    .fs_ret   (fs_ret),
    .sync     (rd_sync),
    .pixel    (dma_pixel),
    .pattern  (pattern),
    .oos      (hdmi_tpm_oos)
  );

  hdmi_tx_pixel_out pixel_out_inst (
    .hdmi_clk  (hdmi_clk),
    .hdmi_rst  (hdmi_rst),
    .srcsel    (srcsel),
    .sync      (rd_sync),
    .dma_pixel (dma_pixel),
    .pattern   (pattern),
    .const_rgb (hdmi_const_rgb),
    .clip_max  (hdmi_clip_max),
    .clip_min  (hdmi_clip_min),
    .hsync     (hdmi_24_hsync),
    .vsync     (hdmi_24_vsync),
    .data_e    (hdmi_24_data_e),
    .data      (hdmi_24_data)
  );

endmodule

// ==== tests/hdmi_tx_tb.sv ====
`include "hdmi_tx_consts.svh"

module hdmi_tx_tb;
  timeunit 1ns;
  timeprecision 100ps;

  logic                        hdmi_clk;
  logic                        hdmi_rst;
  logic                        vdma_clk;
  logic                        vdma_wr;
  logic [`HDMI_TX_ADDR_W-1:0]  vdma_waddr;
  logic [`HDMI_TX_WORD_W-1:0]  vdma_wdata;
  logic                        vdma_fs_ret_toggle;
  logic [`HDMI_TX_ADDR_W-1:0]  vdma_fs_waddr;
  logic [1:0]                  hdmi_srcsel;
  logic [`HDMI_TX_PIXEL_W-1:0] hdmi_const_rgb;
  logic [`HDMI_TX_PIXEL_W-1:0] hdmi_clip_max;
  logic [`HDMI_TX_PIXEL_W-1:0] hdmi_clip_min;
  logic [`HDMI_TX_CNT_W-1:0]   hdmi_hl_width;
  logic [`HDMI_TX_CNT_W-1:0]   hdmi_hs_width;
  logic [`HDMI_TX_CNT_W-1:0]   hdmi_he_min;
  logic [`HDMI_TX_CNT_W-1:0]   hdmi_he_max;
  logic [`HDMI_TX_CNT_W-1:0]   hdmi_vf_width;
  logic [`HDMI_TX_CNT_W-1:0]   hdmi_vs_width;
  logic [`HDMI_TX_CNT_W-1:0]   hdmi_ve_min;
  logic [`HDMI_TX_CNT_W-1:0]   hdmi_ve_max;
  logic                        hdmi_24_hsync;
  logic                        hdmi_24_vsync;
  logic                        hdmi_24_data_e;
  logic [`HDMI_TX_PIXEL_W-1:0] hdmi_24_data;
  logic                        hdmi_fs_toggle;
  logic [`HDMI_TX_ADDR_W-1:0]  hdmi_raddr_g;
  logic                        hdmi_tpm_oos;
  logic                        hdmi_status;

  // one row per test, columns as in the vectors file
  int          vec_tab [16][17];
  int          n_vec = 0;
  int          err_count = 0;
  int          check_count = 0;
  longint      limit_ns = 0;
  integer      seed = 10760;
  int          corrupt_idx = -1;
  logic [8:0]  cur_faddr = '0;

  // current test
  int          t_id;
  int          t_src;
  int          t_frames;
  int          t_hl;
  int          t_hs;
  int          t_he;
  int          t_vf;
  int          t_vs;
  int          t_ve;
  int          t_words;
  int          t_pix;
  logic [23:0] t_clip_min;
  logic [23:0] t_clip_max;
  logic [23:0] t_const;

  hdmi_tx_top hdmi_tx_top_inst (.*);

  initial begin
    hdmi_clk = 1'b0;
    forever #10 hdmi_clk = ~hdmi_clk;
  end

  initial begin
    vdma_clk = 1'b0;
    forever #15 vdma_clk = ~vdma_clk;
  end

  // **********************************************************************
  // dma side, answers every frame start with address and return toggle
  // **********************************************************************

  initial begin
    @(negedge hdmi_rst);
    forever begin
      @(hdmi_fs_toggle);
      @(negedge vdma_clk);
      vdma_fs_waddr = cur_faddr;
      @(negedge vdma_clk);
      vdma_fs_ret_toggle = ~vdma_fs_ret_toggle;
    end
  end

  initial begin
    wait (limit_ns > 0);
    #(limit_ns);
    $display("Timeout: the run did not finish within %0d ns", limit_ns);
    $display(">>> FAIL");
    $finish;
  end

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    check_count++;
    if (actual !== expected) begin
      err_count++;
      $display("Mismatch at %0t ns: %s, got %0h expected %0h", $time, what, actual, expected);
    end
  endtask

  function automatic logic [23:0] clamp_pixel(input logic [23:0] val,
                                              input logic [23:0] lo,
                                              input logic [23:0] hi);
    logic [23:0] res;
    int          c;
    res = val;
    for (c = 0; c < 3; c++) begin
      if (val[c*8 +: 8] > hi[c*8 +: 8]) begin
        res[c*8 +: 8] = hi[c*8 +: 8];
      end else if (val[c*8 +: 8] < lo[c*8 +: 8]) begin
        res[c*8 +: 8] = lo[c*8 +: 8];
      end
    end
    return res;
  endfunction

  // word address in gray code
  function automatic logic [8:0] gray_code(input logic [8:0] bin);
    logic [8:0] g;
    int         i;
    g[8] = bin[8];
    for (i = 0; i < 8; i++) begin
      g[i] = bin[i + 1] ^ bin[i];
    end
    return g;
  endfunction

  // counter value held in the buffer, one pixel may be spoiled
  function automatic logic [23:0] buffer_pixel(input int idx);
    logic [23:0] px;
    px = 24'(idx);
    if (idx == corrupt_idx) begin
      px = px ^ 24'h5a5a5a;
    end
    return px;
  endfunction

  task automatic fill_buffer(input int base, input int words);
    int k;
    for (k = 0; k < words; k++) begin
      @(negedge vdma_clk);
      vdma_wr    = 1'b1;
      vdma_waddr = 9'(base + k);
      vdma_wdata = {buffer_pixel(2 * k + 1), buffer_pixel(2 * k)};
    end
    @(negedge vdma_clk);
    vdma_wr = 1'b0;
  endtask

  task automatic apply_vector(input int r);
    t_id       = vec_tab[r][0];
    t_src      = vec_tab[r][1];
    t_frames   = vec_tab[r][2];
    t_hl       = vec_tab[r][3];
    t_hs       = vec_tab[r][4];
    t_he       = vec_tab[r][6] - vec_tab[r][5];
    t_vf       = vec_tab[r][7];
    t_vs       = vec_tab[r][8];
    t_ve       = vec_tab[r][10] - vec_tab[r][9];
    t_clip_min = vec_tab[r][11][23:0];
    t_clip_max = vec_tab[r][12][23:0];
    t_const    = vec_tab[r][13][23:0];
    cur_faddr  = vec_tab[r][14][8:0];
    t_words    = vec_tab[r][15];
    t_pix      = vec_tab[r][16];
    hdmi_hl_width  = vec_tab[r][3][15:0];
    hdmi_hs_width  = vec_tab[r][4][15:0];
    hdmi_he_min    = vec_tab[r][5][15:0];
    hdmi_he_max    = vec_tab[r][6][15:0];
    hdmi_vf_width  = vec_tab[r][7][15:0];
    hdmi_vs_width  = vec_tab[r][8][15:0];
    hdmi_ve_min    = vec_tab[r][9][15:0];
    hdmi_ve_max    = vec_tab[r][10][15:0];
    hdmi_clip_min  = t_clip_min;
    hdmi_clip_max  = t_clip_max;
    hdmi_const_rgb = t_const;
  endtask

  task automatic check_off();
    check_value(32'(hdmi_status), 32'd1, "status after reset");
    repeat (t_hl * t_vf) begin
      @(negedge hdmi_clk);
      check_value(32'({hdmi_24_hsync, hdmi_24_vsync, hdmi_24_data_e}), 32'd0,
                  "sync output active with source off");
    end
  endtask

  task automatic find_vsync_rise();
    while (hdmi_24_vsync) @(negedge hdmi_clk);
    while (!hdmi_24_vsync) @(negedge hdmi_clk);
  endtask

  // **********************************************************************
  // frame measurement, from one vsync rise to the next
  // **********************************************************************

  task automatic run_frames();
    int          frame;
    int          hs_run;
    int          de_run;
    int          vs_lines;
    int          de_lines;
    int          toggles;
    int          pix;
    int          oos_hits;
    logic        prev_hs;
    logic        prev_vs;
    logic        prev_de;
    logic        prev_tog;
    logic        in_frame;
    logic [23:0] src_px;
    frame = 0;
    {hs_run, de_run, vs_lines, de_lines, toggles, pix, oos_hits} = '0;
    // the first rise after enable may land mid-frame
    find_vsync_rise();
    find_vsync_rise();
    {prev_hs, prev_vs, prev_de, in_frame} = 4'b0000;
    prev_tog = hdmi_fs_toggle;
    forever begin
      if (hdmi_24_vsync && !prev_vs && in_frame) begin
        check_value(32'(vs_lines), 32'(t_vs), "lines with vsync");
        check_value(32'(de_lines), 32'(t_ve), "lines with data_e");
        check_value(32'(pix), 32'(t_pix), "data_e pixels per frame");
        check_value(32'(toggles), 32'd1, "frame start toggles per frame");
        // read address sits one word past the frame's last pixel pair
        check_value(32'(hdmi_raddr_g),
                    32'(gray_code(9'((2 * int'(cur_faddr) + t_pix) / 2))),
                    "gray read address at frame end");
        if (t_src == 1 && corrupt_idx >= 0) begin
          check_value(32'(oos_hits > 0), 32'd1, "monitor flag on corrupted frame");
        end
        frame++;
        {hs_run, de_run, vs_lines, de_lines, toggles, pix, oos_hits} = '0;
        if (frame == t_frames) begin
          break;
        end
      end
      in_frame = 1'b1;
      if (hdmi_24_hsync) begin
        hs_run++;
        if (!prev_hs && hdmi_24_vsync) begin
          vs_lines++;
        end
      end else if (prev_hs) begin
        check_value(32'(hs_run), 32'(t_hs), "hsync cycles per line");
        hs_run = 0;
      end
      if (hdmi_24_data_e) begin
        case (t_src)
          1:       src_px = buffer_pixel(pix);
          2:       src_px = 24'(pix);
          default: src_px = t_const;
        endcase
        check_value(32'(hdmi_24_data), 32'(clamp_pixel(src_px, t_clip_min, t_clip_max)),
                    "pixel value");
        de_run++;
        pix++;
        if (!prev_de) begin
          de_lines++;
        end
      end else if (prev_de) begin
        check_value(32'(de_run), 32'(t_he), "data_e cycles per line");
        de_run = 0;
      end
      if (hdmi_fs_toggle != prev_tog) begin
        toggles++;
      end
      if (t_src == 1 && corrupt_idx < 0) begin
        check_value(32'(hdmi_tpm_oos), 32'd0, "monitor flag on clean dma data");
      end
      if (hdmi_tpm_oos) begin
        oos_hits++;
      end
      {prev_hs, prev_vs, prev_de, prev_tog} =
        {hdmi_24_hsync, hdmi_24_vsync, hdmi_24_data_e, hdmi_fs_toggle};
      @(negedge hdmi_clk);
    end
  endtask

  initial begin
    int          fd;
    int          code;
    int          r;
    int          errs_before;
    logic [7:0]  ch;
    hdmi_rst = 1'b1;
    vdma_wr = 1'b0;
    vdma_waddr = '0;
    vdma_wdata = '0;
    vdma_fs_ret_toggle = 1'b0;
    vdma_fs_waddr = '0;
    hdmi_srcsel = 2'd0;
    hdmi_const_rgb = '0;
    hdmi_clip_min = '0;
    hdmi_clip_max = '1;
    {hdmi_hl_width, hdmi_hs_width, hdmi_he_min, hdmi_he_max} = '0;
    {hdmi_vf_width, hdmi_vs_width, hdmi_ve_min, hdmi_ve_max} = '0;

    fd = $fopen("tests/hdmi_tx_vectors.txt", "r");
    if (fd == 0) begin
      $display("Could not open tests/hdmi_tx_vectors.txt");
      $display(">>> FAIL");
      $finish;
    end else begin
      // test rows start with t, comment rows with #
      code = $fscanf(fd, "%c", ch);
      while (code == 1) begin
        if (ch == "#") begin
          while (code == 1 && ch != "\n") code = $fscanf(fd, "%c", ch);
        end else if (ch == "t" && n_vec < 16) begin
          code = $fscanf(fd, "%d %d %d %d %d %d %d %d %d %d %d %h %h %h %h %d %d",
            vec_tab[n_vec][0], vec_tab[n_vec][1], vec_tab[n_vec][2], vec_tab[n_vec][3],
            vec_tab[n_vec][4], vec_tab[n_vec][5], vec_tab[n_vec][6], vec_tab[n_vec][7],
            vec_tab[n_vec][8], vec_tab[n_vec][9], vec_tab[n_vec][10], vec_tab[n_vec][11],
            vec_tab[n_vec][12], vec_tab[n_vec][13], vec_tab[n_vec][14],
            vec_tab[n_vec][15], vec_tab[n_vec][16]);
          if (code == 17) begin
            n_vec++;
          end else begin
            err_count++;
            $display("Vector row %0d in the data file could not be parsed", n_vec + 1);
          end
        end
        code = $fscanf(fd, "%c", ch);
      end
      $fclose(fd);
      if (n_vec == 0) begin
        err_count++;
        $display("The data file holds no test rows");
      end

      // budget: alignment plus measured frames, dma fill, all doubled
      limit_ns = 16 * 20;
      for (r = 0; r < n_vec; r++) begin
        limit_ns += longint'(vec_tab[r][2] + 2) * vec_tab[r][3] * vec_tab[r][7] * 20;
        limit_ns += longint'(vec_tab[r][15]) * 30 + 200;
      end
      limit_ns = 2 * limit_ns;

      repeat (16) @(posedge hdmi_clk);
      @(negedge hdmi_clk);
      hdmi_rst = 1'b0;

      for (r = 0; r < n_vec; r++) begin
        errs_before = err_count;
        @(negedge hdmi_clk);
        hdmi_srcsel = 2'd0;
        repeat (8) @(negedge hdmi_clk);
        apply_vector(r);
        corrupt_idx = -1;
        if (t_id == 5 && t_pix > 0) begin
          corrupt_idx = int'($unsigned($random(seed)) % t_pix);
        end
        if (t_words > 0) begin
          fill_buffer(int'(cur_faddr), t_words);
        end
        @(negedge hdmi_clk);
        if (t_src == 0) begin
          check_off();
        end else begin
          hdmi_srcsel = t_src[1:0];
          run_frames();
        end
        $display("test %0d, source %0d, %0d frames: %0d errors",
                 t_id, t_src, t_frames, err_count - errs_before);
      end

      $display("tests %0d, checks %0d, errors %0d", n_vec, check_count, err_count);
      if (err_count == 0) begin
        $display(">>> PASS");
      end else begin
        $display(">>> FAIL");
      end
      $finish;
    end
  end

endmodule

// ==== tests/hdmi_tx_vectors.txt ====
# t id src frames hl_width hs_width he_min he_max vf_width vs_width ve_min ve_max
#   clip_min clip_max const_rgb fs_waddr (hex) fill_words de_pixels_per_frame
# src: 0 off, 1 dma, 2 pattern, 3 constant
t 1 0 1 40 4 8 36 20 2 6 18 000000 ffffff 000000 000 0 0
t 2 3 2 40 4 8 36 20 2 6 18 000000 ffffff 404040 000 0 336
t 3 3 1 40 4 8 36 20 2 6 18 202020 c0c0c0 f01080 000 0 336
t 3 3 1 48 6 10 42 24 3 7 20 202020 c0c0c0 10e0a0 000 0 416
t 4 1 2 40 4 8 36 20 2 6 18 000000 ffffff 000000 040 168 336
t 5 1 1 40 4 8 36 20 2 6 18 000000 ffffff 000000 100 168 336
t 6 2 2 40 4 8 36 20 2 6 18 000000 ffffff 000000 000 0 336

// ==== sources.f ====
+incdir+logic
logic/hdmi_tx_pkg.sv
logic/video_sync_if.sv
logic/hdmi_tx_timing.sv
logic/hdmi_tx_line_buffer.sv
logic/hdmi_tx_line_reader.sv
logic/hdmi_tx_test_pattern.sv
logic/hdmi_tx_pixel_out.sv
logic/hdmi_tx_top.sv
tests/hdmi_tx_tb.sv
